//--- Bender.yml
package:
  name: fsync_cc

sources:
  - fsync_pkg.sv
  - fsync_fifo.sv
  - fsync_msg_build.sv
  - fsync_local_rf.sv
  - fsync_remote_rf.sv
  - fsync_cc_ctrl.sv
  - fsync_cc_top.sv
  - target: test
    files:
      - fsync_cc_tb.sv

//--- filelist.f
fsync_pkg.sv
fsync_fifo.sv
fsync_msg_build.sv
fsync_local_rf.sv
fsync_remote_rf.sv
fsync_cc_ctrl.sv
fsync_cc_top.sv
fsync_cc_tb.sv

//--- fsync_cc_ctrl.sv
// ##################################################
// action decode, push strobes, back-routing bits
// and error flags
// ##################################################

`timescale 1ns/1ps

module fsync_cc_ctrl (
  input  fsync_pkg::rx_ctrl_t            rx_ctrl_i[fsync_pkg::N_RX],
  input  logic                           loc_present_i[fsync_pkg::N_RX],
  input  logic                           loc_bypass_i[fsync_pkg::N_RX],
  input  logic                           loc_err_i[fsync_pkg::N_RX],
  input  logic                           rem_present_i[fsync_pkg::N_RX],
  input  logic                           rem_bypass_i[fsync_pkg::N_RX],
  input  logic                           rem_err_i[fsync_pkg::N_RX],
  output logic                           check_local_o[fsync_pkg::N_RX],
  output logic                           set_remote_o[fsync_pkg::N_RX],
  output logic                           push_local_o[fsync_pkg::N_RX],
  output logic                           push_remote_o[fsync_pkg::N_RX],
  input  logic                           local_full_i[fsync_pkg::N_RX],
  input  logic                           remote_full_i[fsync_pkg::N_RX],
  input  logic                           local_empty_i[fsync_pkg::N_RX],
  input  logic                           remote_empty_i[fsync_pkg::N_RX],
  input  logic                           local_pop_i[fsync_pkg::N_RX],
  input  logic                           remote_pop_i[fsync_pkg::N_RX],
  input  logic                           err_ovf_rx_i[fsync_pkg::N_RX],
  input  logic                           err_ovf_tx_i,
  input  logic                           check_br_i,
  input  logic [fsync_pkg::SD_WIDTH-1:0] br_sd_i,
  input  logic                           br_err_i,
  output logic                           en_br_o,
  output logic                           ws_br_o,
  output logic                           detected_error_o[fsync_pkg::N_RX+1]
);

  import fsync_pkg::*;

  action_e act[N_RX];

  always_comb begin
    for (int p = 0; p < N_RX; p++) begin
      if (!rx_ctrl_i[p].check_rf) begin
        act[p] = ACT_NONE;
      end else if (!rx_ctrl_i[p].is_local) begin
        act[p] = ACT_FWD;
      end else if (rx_ctrl_i[p].is_root) begin
        act[p] = ACT_ROOT;
      end else begin
        act[p] = ACT_AGGR;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < N_RX; p++) begin
      check_local_o[p] = 1'b0;
      set_remote_o[p]  = 1'b0;
      push_local_o[p]  = 1'b0;
      push_remote_o[p] = 1'b0;
      unique case (act[p])
        ACT_FWD: begin
          set_remote_o[p] = 1'b1;  // direction only.
        end
        ACT_AGGR: begin
          set_remote_o[p]  = 1'b1;
          push_remote_o[p] = (rem_present_i[p] | rem_bypass_i[p]) & ~rem_err_i[p];
          push_local_o[p]  = rem_err_i[p];  // error response back down.
        end
        ACT_ROOT: begin
          check_local_o[p] = 1'b1;
          push_local_o[p]  = loc_present_i[p] | loc_bypass_i[p] | loc_err_i[p];
        end
        default: begin
        end
      endcase
    end
  end

  // back-routing, both bits low for an unknown id
  assign en_br_o = check_br_i & ~br_err_i & br_sd_i[0];
  assign ws_br_o = check_br_i & ~br_err_i & br_sd_i[1];

  always_comb begin
    for (int p = 0; p < N_RX; p++) begin
      detected_error_o[p] = err_ovf_rx_i[p]
                          | (local_empty_i[p] & local_pop_i[p])
                          | (local_full_i[p] & push_local_o[p])
                          | (remote_empty_i[p] & remote_pop_i[p])
                          | (remote_full_i[p] & push_remote_o[p]);
    end
    detected_error_o[N_RX] = err_ovf_tx_i;  // tx port.
  end

endmodule

//--- fsync_cc_tb.sv
// ##################################################
// testbench of the fractal sync control core, cycle
// stimulus and expected values from the stim file
// ##################################################

`timescale 1ns/1ps

module fsync_cc_tb;

  import fsync_pkg::*;

  localparam time CLK_PERIOD = 100ns;
  localparam int  RST_CYCLES = 10;

  logic     clk_i;
  logic     rst_ni;
  req_in_t  req[N_RX];
  rx_ctrl_t rx_ctrl[N_RX];
  logic     err_ovf_rx[N_RX];
  rsp_t     rsp;
  logic     check_br;
  logic     err_ovf_tx;
  logic     en_br;
  logic     ws_br;
  logic     local_empty[N_RX];
  rsp_t     local_rsp[N_RX];
  logic     local_pop[N_RX];
  logic     remote_empty[N_RX];
  req_out_t remote_req[N_RX];
  logic     remote_pop[N_RX];
  logic     detected_error[N_RX+1];

  string lines[$];       // whole stim file.
  bit    loaded;
  string cur_test;
  int    test_errs;
  int    file_errs;
  int    n_pass;
  int    n_fail;

  fsync_cc_top u_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req),
    .rx_ctrl_i        (rx_ctrl),
    .err_ovf_rx_i     (err_ovf_rx),
    .rsp_i            (rsp),
    .check_br_i       (check_br),
    .err_ovf_tx_i     (err_ovf_tx),
    .en_br_o          (en_br),
    .ws_br_o          (ws_br),
    .local_empty_o    (local_empty),
    .local_rsp_o      (local_rsp),
    .local_pop_i      (local_pop),
    .remote_empty_o   (remote_empty),
    .remote_req_o     (remote_req),
    .remote_pop_i     (remote_pop),
    .detected_error_o (detected_error)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic load_stim();
    int    fd;
    string line;
    fd = $fopen("fsync_stim.txt", "r");
    if (fd == 0) begin
      $display("stim file fsync_stim.txt could not be opened");
      file_errs++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      lines.push_back(line);
    end
    $fclose(fd);
  endtask

  // port 0 completes an aggregation, then its directions are looked up
  task automatic append_port0_aggregation();
    lines.push_back("T aggregation_port0");
    lines.push_back("C 000 0 168 6 0 0 0 0 0 0 0 0 3 3 - - - -");
    lines.push_back("C 1c8 6 000 0 0 0 0 0 0 0 0 0 3 3 - - - -");
    lines.push_back("C 000 0 000 0 0 0 0 0 0 1 0 0 3 2 - - e8 -");
    lines.push_back("C 000 0 000 0 0 8 1 0 0 0 0 3 3 3 - - - -");
  endtask

  task automatic check_field(input string name, input string exp_s, input logic [15:0] got);
    logic [15:0] exp_v;
    if (exp_s == "-") begin
      return;  // don't care.
    end
    exp_v = exp_s.atohex();
    assert (got === exp_v) else begin
      $display("ERROR t=%0t %s expected=%0h actual=%0h", $time, name, exp_v, got);
      test_errs++;
    end
  endtask

  task automatic finish_test();
    if (cur_test == "") begin
      return;
    end
    if (test_errs == 0) begin
      $display("test %s: passed", cur_test);
      n_pass++;
    end else begin
      $display("test %s: failed with %0d errors", cur_test, test_errs);
      n_fail++;
    end
  endtask

  // one stim line: drive at the edge, check just before the next one
  task automatic run_cycle(input logic [15:0] in_v[10], input string ex_s[8]);
    @(posedge clk_i);
    req[0]        <= in_v[0][8:0];
    rx_ctrl[0]    <= in_v[1][2:0];
    req[1]        <= in_v[2][8:0];
    rx_ctrl[1]    <= in_v[3][2:0];
    err_ovf_rx[0] <= in_v[4][0];
    err_ovf_rx[1] <= in_v[4][1];
    rsp           <= {4'b0000, in_v[5][3:0], 1'b0};  // only the id is looked up.
    check_br      <= in_v[6][0];
    err_ovf_tx    <= in_v[7][0];
    local_pop[0]  <= in_v[8][0];
    local_pop[1]  <= in_v[8][1];
    remote_pop[0] <= in_v[9][0];
    remote_pop[1] <= in_v[9][1];
    #(CLK_PERIOD - 10ns);
    check_field("detected_error_o", ex_s[0],
                16'({detected_error[2], detected_error[1], detected_error[0]}));
    check_field("{ws_br_o,en_br_o}", ex_s[1], 16'({ws_br, en_br}));
    check_field("local_empty_o", ex_s[2], 16'({local_empty[1], local_empty[0]}));
    check_field("remote_empty_o", ex_s[3], 16'({remote_empty[1], remote_empty[0]}));
    check_field("local_rsp_o[0]", ex_s[4], 16'(local_rsp[0]));
    check_field("local_rsp_o[1]", ex_s[5], 16'(local_rsp[1]));
    check_field("remote_req_o[0]", ex_s[6], 16'(remote_req[0]));
    check_field("remote_req_o[1]", ex_s[7], 16'(remote_req[1]));
  endtask

  initial begin
    string       tag;
    string       name;
    string       ex_s[8];
    logic [15:0] in_v[10];
    int          n;
    rst_ni     = 1'b0;
    rsp        = '0;
    check_br   = 1'b0;
    err_ovf_tx = 1'b0;
    for (int p = 0; p < N_RX; p++) begin
      req[p]        = '0;
      rx_ctrl[p]    = '0;
      err_ovf_rx[p] = 1'b0;
      local_pop[p]  = 1'b0;
      remote_pop[p] = 1'b0;
    end
    load_stim();
    append_port0_aggregation();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    foreach (lines[i]) begin
      n = $sscanf(lines[i], "%s", tag);
      if (n < 1 || tag == "#") begin
        continue;
      end
      if (tag == "T") begin
        n = $sscanf(lines[i], "%s %s", tag, name);
        finish_test();
        cur_test  = name;
        test_errs = 0;
      end else if (tag == "C") begin
        n = $sscanf(lines[i], "%s %h %h %h %h %h %h %h %h %h %h %s %s %s %s %s %s %s %s",
                    tag, in_v[0], in_v[1], in_v[2], in_v[3], in_v[4], in_v[5], in_v[6],
                    in_v[7], in_v[8], in_v[9], ex_s[0], ex_s[1], ex_s[2], ex_s[3],
                    ex_s[4], ex_s[5], ex_s[6], ex_s[7]);
        if (n != 19) begin
          $display("stim line %0d is malformed and was skipped", i + 1);
          file_errs++;
        end else begin
          run_cycle(in_v, ex_s);
        end
      end else begin
        $display("stim line %0d has an unknown tag %s", i + 1, tag);
        file_errs++;
      end
    end
    finish_test();
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0 && file_errs == 0 && n_pass > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // run length is reset plus one cycle per stim line, with margin
  initial begin
    wait (loaded);
    #((lines.size() + 20) * CLK_PERIOD);
    $display("timeout: the run hung and did not end within %0d cycles", lines.size() + 20);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- fsync_cc_top.sv
// ##################################################
// control core of a 1D fractal sync node
// ##################################################

`timescale 1ns/1ps

module fsync_cc_top #(
  parameter int unsigned N_LOCAL_REGS  = 12,
  parameter int unsigned N_REMOTE_REGS = 12,
  parameter int unsigned FIFO_DEPTH    = 2,
  parameter int unsigned LVL_OFFSET    = 0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  fsync_pkg::req_in_t  req_i[fsync_pkg::N_RX],
  input  fsync_pkg::rx_ctrl_t rx_ctrl_i[fsync_pkg::N_RX],
  input  logic                err_ovf_rx_i[fsync_pkg::N_RX],
  input  fsync_pkg::rsp_t     rsp_i,
  input  logic                check_br_i,
  input  logic                err_ovf_tx_i,
  output logic                en_br_o,
  output logic                ws_br_o,
  output logic                local_empty_o[fsync_pkg::N_RX],
  output fsync_pkg::rsp_t     local_rsp_o[fsync_pkg::N_RX],
  input  logic                local_pop_i[fsync_pkg::N_RX],
  output logic                remote_empty_o[fsync_pkg::N_RX],
  output fsync_pkg::req_out_t remote_req_o[fsync_pkg::N_RX],
  input  logic                remote_pop_i[fsync_pkg::N_RX],
  output logic                detected_error_o[fsync_pkg::N_RX+1]
);

  import fsync_pkg::*;

  logic [ID_WIDTH-1:0] req_id[N_RX];
  logic                check_local[N_RX];
  logic                set_remote[N_RX];
  logic                loc_present[N_RX];
  logic                loc_bypass[N_RX];
  logic                loc_err[N_RX];
  logic                rem_present[N_RX];
  logic                rem_bypass[N_RX];
  logic                rem_err[N_RX];
  logic                push_local[N_RX];
  logic                push_remote[N_RX];
  logic                local_full[N_RX];
  logic                remote_full[N_RX];
  rsp_t                local_rsp[N_RX];
  req_out_t            remote_req[N_RX];
  logic [SD_WIDTH-1:0] br_sd;
  logic                br_err;

  fsync_cc_ctrl u_ctrl (
    .rx_ctrl_i        (rx_ctrl_i),
    .loc_present_i    (loc_present),
    .loc_bypass_i     (loc_bypass),
    .loc_err_i        (loc_err),
    .rem_present_i    (rem_present),
    .rem_bypass_i     (rem_bypass),
    .rem_err_i        (rem_err),
    .check_local_o    (check_local),
    .set_remote_o     (set_remote),
    .push_local_o     (push_local),
    .push_remote_o    (push_remote),
    .local_full_i     (local_full),
    .remote_full_i    (remote_full),
    .local_empty_i    (local_empty_o),
    .remote_empty_i   (remote_empty_o),
    .local_pop_i      (local_pop_i),
    .remote_pop_i     (remote_pop_i),
    .err_ovf_rx_i     (err_ovf_rx_i),
    .err_ovf_tx_i     (err_ovf_tx_i),
    .check_br_i       (check_br_i),
    .br_sd_i          (br_sd),
    .br_err_i         (br_err),
    .en_br_o          (en_br_o),
    .ws_br_o          (ws_br_o),
    .detected_error_o (detected_error_o)
  );

  fsync_local_rf #(
    .N_LOCAL_REGS (N_LOCAL_REGS)
  ) u_local_rf (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .id_i      (req_id),
    .check_i   (check_local),
    .present_o (loc_present),
    .bypass_o  (loc_bypass),
    .id_err_o  (loc_err)
  );

  fsync_remote_rf #(
    .N_REMOTE_REGS (N_REMOTE_REGS)
  ) u_remote_rf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .id_i       (req_id),
    .set_i      (set_remote),
    .present_o  (rem_present),
    .bypass_o   (rem_bypass),
    .id_err_o   (rem_err),
    .br_id_i    (rsp_i.id),
    .br_check_i (check_br_i),
    .br_sd_o    (br_sd),
    .br_err_o   (br_err)
  );

  for (genvar p = 0; p < N_RX; p++) begin : gen_port
    assign req_id[p] = req_i[p].id;

    // only the rf that was strobed can flag the id
    fsync_msg_build #(
      .LVL_OFFSET (LVL_OFFSET)
    ) u_msg_build (
      .req_i    (req_i[p]),
      .id_err_i (loc_err[p] | rem_err[p]),
      .rsp_o    (local_rsp[p]),
      .req_o    (remote_req[p])
    );

    fsync_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .elem_t     (rsp_t)
    ) u_local_fifo (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .push_i  (push_local[p]),
      .elem_i  (local_rsp[p]),
      .pop_i   (local_pop_i[p]),
      .elem_o  (local_rsp_o[p]),
      .empty_o (local_empty_o[p]),
      .full_o  (local_full[p])
    );

    fsync_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .elem_t     (req_out_t)
    ) u_remote_fifo (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .push_i  (push_remote[p]),
      .elem_i  (remote_req[p]),
      .pop_i   (remote_pop_i[p]),
      .elem_o  (remote_req_o[p]),
      .empty_o (remote_empty_o[p]),
      .full_o  (remote_full[p])
    );
  end

endmodule

//--- fsync_fifo.sv
// ##################################################
// sequential circular FIFO of one element type
// ##################################################

`timescale 1ns/1ps

module fsync_fifo #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter type         elem_t     = logic
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  elem_t elem_i,
  input  logic  pop_i,
  output elem_t elem_o,
  output logic  empty_o,
  output logic  full_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  elem_t            mem_q[FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(FIFO_DEPTH));
  assign do_push = push_i & ~full_o;  // a push into a full fifo is lost.
  assign do_pop  = pop_i & ~empty_o;
  assign elem_o  = mem_q[rd_ptr_q];   // head stays until popped.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= elem_i;
    end
  end

endmodule

//--- fsync_local_rf.sv
// ##################################################
// root arrival flags, one per barrier id
// ##################################################

`timescale 1ns/1ps

module fsync_local_rf #(
  parameter int unsigned N_LOCAL_REGS = 12
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [fsync_pkg::ID_WIDTH-1:0] id_i[fsync_pkg::N_RX],
  input  logic                           check_i[fsync_pkg::N_RX],
  output logic                           present_o[fsync_pkg::N_RX],
  output logic                           bypass_o[fsync_pkg::N_RX],
  output logic                           id_err_o[fsync_pkg::N_RX]
);

  import fsync_pkg::*;

  logic [N_LOCAL_REGS-1:0] flag_q;
  logic [N_LOCAL_REGS-1:0] flag_d;
  logic [N_RX-1:0]         valid;
  logic                    same_id;

  always_comb begin
    for (int p = 0; p < N_RX; p++) begin
      valid[p] = (id_i[p] < N_LOCAL_REGS);
    end
  end

  // both children arrive together, barrier done at once
  assign same_id = check_i[0] & check_i[1] & valid[0] & (id_i[0] == id_i[1]);

  always_comb begin
    flag_d = flag_q;
    for (int p = 0; p < N_RX; p++) begin
      present_o[p] = 1'b0;
      bypass_o[p]  = 1'b0;
      id_err_o[p]  = check_i[p] & ~valid[p];
    end
    bypass_o[0] = same_id;  // flag left as is.
    if (!same_id) begin
      for (int p = 0; p < N_RX; p++) begin
        if (check_i[p] && valid[p]) begin
          if (flag_q[id_i[p]]) begin
            present_o[p]      = 1'b1;  // second arrival.
            flag_d[id_i[p]]   = 1'b0;
          end else begin
            flag_d[id_i[p]]   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flag_q <= '0;
    end else begin
      flag_q <= flag_d;
    end
  end

endmodule

//--- fsync_msg_build.sv
// ##################################################
// level encoder, local response and forwarded
// request of one RX port
// ##################################################

`timescale 1ns/1ps

module fsync_msg_build #(
  parameter int unsigned LVL_OFFSET = 0
) (
  input  fsync_pkg::req_in_t  req_i,
  input  logic                id_err_i,
  output fsync_pkg::rsp_t     rsp_o,
  output fsync_pkg::req_out_t req_o
);

  import fsync_pkg::*;

  logic [LVL_WIDTH-1:0] lvl;

  // highest set aggregate bit gives the level
  always_comb begin
    lvl = '0;
    for (int j = 0; j < AGGR_WIDTH; j++) begin
      if (req_i.aggr[j]) begin
        lvl = LVL_WIDTH'(j + LVL_OFFSET);  // later bits override.
      end
    end
  end

  always_comb begin
    rsp_o.wake  = 1'b1;
    rsp_o.lvl   = lvl;
    rsp_o.id    = req_i.id;
    rsp_o.error = id_err_i;
  end

  always_comb begin
    req_o.sync = req_i.sync;
    req_o.aggr = req_i.aggr[AGGR_WIDTH-1:1];  // shifted down one level.
    req_o.id   = req_i.id;
  end

endmodule

//--- fsync_pkg.sv
// ##################################################
// widths, request action enum and message structs
// of the fractal sync control core
// ##################################################

package fsync_pkg;

  localparam int unsigned AGGR_WIDTH = 4;  // incoming aggregate field.
  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned LVL_WIDTH  = 3;
  localparam int unsigned N_RX       = 2;  // east-north and west-south children.
  localparam int unsigned SD_WIDTH   = 2;  // bit 0 east-north, bit 1 west-south.

  typedef enum logic [1:0] {
    ACT_NONE = 2'd0,  // no request.
    ACT_FWD  = 2'd1,  // non-local, record direction only.
    ACT_AGGR = 2'd2,  // local, not root.
    ACT_ROOT = 2'd3   // local and root.
  } action_e;

  typedef struct packed {
    logic                  sync;
    logic [AGGR_WIDTH-1:0] aggr;
    logic [ID_WIDTH-1:0]   id;
  } req_in_t;

  // one aggregate bit fewer once a level has been passed
  typedef struct packed {
    logic                  sync;
    logic [AGGR_WIDTH-2:0] aggr;
    logic [ID_WIDTH-1:0]   id;
  } req_out_t;

  typedef struct packed {
    logic                 wake;
    logic [LVL_WIDTH-1:0] lvl;
    logic [ID_WIDTH-1:0]  id;
    logic                 error;
  } rsp_t;

  typedef struct packed {
    logic check_rf;
    logic is_local;
    logic is_root;
  } rx_ctrl_t;

endpackage

//--- fsync_remote_rf.sv
// ##################################################
// directly mapped direction store, aggregation
// check and back-routing lookup
// ##################################################

`timescale 1ns/1ps

module fsync_remote_rf #(
  parameter int unsigned N_REMOTE_REGS = 12
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [fsync_pkg::ID_WIDTH-1:0] id_i[fsync_pkg::N_RX],
  input  logic                           set_i[fsync_pkg::N_RX],
  output logic                           present_o[fsync_pkg::N_RX],
  output logic                           bypass_o[fsync_pkg::N_RX],
  output logic                           id_err_o[fsync_pkg::N_RX],
  input  logic [fsync_pkg::ID_WIDTH-1:0] br_id_i,
  input  logic                           br_check_i,
  output logic [fsync_pkg::SD_WIDTH-1:0] br_sd_o,
  output logic                           br_err_o
);

  import fsync_pkg::*;

  logic [SD_WIDTH-1:0] sd_q[N_REMOTE_REGS];
  logic [SD_WIDTH-1:0] sd_d[N_REMOTE_REGS];
  logic [N_RX-1:0]     valid;
  logic                br_valid;
  logic                same_id;

  always_comb begin
    for (int p = 0; p < N_RX; p++) begin
      valid[p] = (id_i[p] < N_REMOTE_REGS);
    end
  end

  assign br_valid = (br_id_i < N_REMOTE_REGS);
  assign br_err_o = ~br_valid;
  assign br_sd_o  = br_valid ? sd_q[br_id_i] : '0;  // masked on a bad id.

  assign same_id = set_i[0] & set_i[1] & valid[0] & (id_i[0] == id_i[1]);

  always_comb begin
    for (int p = 0; p < N_RX; p++) begin
      id_err_o[p]  = set_i[p] & ~valid[p];
      bypass_o[p]  = 1'b0;
      present_o[p] = 1'b0;
      if (set_i[p] && valid[p] && !same_id) begin
        present_o[p] = sd_q[id_i[p]][N_RX-1-p];  // other child already in.
      end
    end
    bypass_o[0] = same_id;
  end

  // lookup clears the entry, an rx set in the same cycle wins
  always_comb begin
    sd_d = sd_q;
    if (br_check_i && br_valid) begin
      sd_d[br_id_i] = '0;
    end
    for (int p = 0; p < N_RX; p++) begin
      if (set_i[p] && valid[p]) begin
        sd_d[id_i[p]][p] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sd_q <= '{default: '0};
    end else begin
      sd_q <= sd_d;
    end
  end

endmodule

//--- fsync_stim.txt
# C req0 ctl0 req1 ctl1 ovf_rx br_id chk_br ovf_tx lpop rpop  det br lemp remp lrsp0 lrsp1 rreq0 rreq1
# hex; pair fields hold port p in bit p, br is {ws,en}, det bit 2 is tx, - skips a check
T reset_state
C 000 0 000 0 0 0 0 0 0 0   0 0 3 3 - - - -
C 000 0 000 0 0 0 0 0 0 0   0 0 3 3 - - - -
T root_barrier
C 143 7 000 0 0 0 0 0 0 0   0 0 3 3 - - - -
C 000 0 000 0 0 0 0 0 0 0   0 0 3 3 - - - -
C 000 0 1a3 7 0 0 0 0 0 0   0 0 3 3 - - - -
C 000 0 000 0 0 0 0 0 0 0   0 0 1 3 - 166 - -
C 000 0 000 0 0 0 0 0 2 0   0 0 1 3 - 166 - -
C 000 0 000 0 0 0 0 0 0 0   0 0 3 3 - - - -
C 115 7 115 7 0 0 0 0 0 0   0 0 3 3 - - - -
C 000 0 000 0 0 0 0 0 0 0   0 0 2 3 10a - - -
C 000 0 000 0 0 0 0 0 1 0   0 0 2 3 10a - - -
C 000 0 000 0 0 0 0 0 0 0   0 0 3 3 - - - -
T aggregation
C 167 6 000 0 0 0 0 0 0 0   0 0 3 3 - - - -
C 000 0 127 6 0 0 0 0 0 0   0 0 3 3 - - - -
C 109 4 000 0 0 0 0 0 0 0   0 0 3 1 - - - 97
C 000 0 10a 4 0 0 0 0 0 2   0 0 3 1 - - - 97
C 000 0 000 0 0 0 0 0 0 0   0 0 3 3 - - - -
T back_routing
C 000 0 000 0 0 7 1 0 0 0   0 3 3 3 - - - -
C 000 0 000 0 0 7 1 0 0 0   0 0 3 3 - - - -
C 000 0 000 0 0 9 1 0 0 0   0 1 3 3 - - - -
C 000 0 000 0 0 a 1 0 0 0   0 2 3 3 - - - -
C 000 0 000 0 0 9 1 0 0 0   0 0 3 3 - - - -
C 000 0 000 0 0 a 1 0 0 0   0 0 3 3 - - - -
T id_errors
C 11c 6 18d 7 0 0 0 0 0 0   0 0 3 3 - - - -
C 000 0 000 0 0 0 0 0 0 0   0 0 0 3 119 17b - -
C 000 0 000 0 0 0 0 0 3 0   0 0 0 3 119 17b - -
C 000 0 000 0 0 c 1 0 0 0   0 0 3 3 - - - -
C 000 0 000 0 0 f 1 0 0 0   0 0 3 3 - - - -
T error_flags
C 000 0 000 0 0 0 0 0 1 0   1 0 3 3 - - - -
C 000 0 000 0 0 0 0 0 0 2   2 0 3 3 - - - -
C 000 0 000 0 0 0 0 1 0 0   4 0 3 3 - - - -
C 000 0 000 0 3 0 0 0 0 0   3 0 3 3 - - - -
C 111 7 111 7 0 0 0 0 0 0   0 0 3 3 - - - -
C 122 7 122 7 0 0 0 0 0 0   0 0 2 3 102 - - -
C 144 7 144 7 0 0 0 0 0 0   1 0 2 3 102 - - -
C 000 0 000 0 0 0 0 0 0 0   0 0 2 3 102 - - -
C 000 0 000 0 0 0 0 0 1 0   0 0 2 3 102 - - -
C 000 0 000 0 0 0 0 0 1 0   0 0 2 3 124 - - -
C 000 0 000 0 0 0 0 0 1 0   1 0 3 3 - - - -
C 000 0 000 0 0 0 0 0 0 0   0 0 3 3 - - - -
